//--- run_sim.sh
#!/bin/sh
# build and run the sv32 mmu testbench with verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module sv32_mmu_tb \
  -Mdir obj_dir -o sim_sv32_mmu \
  -f sv32_mmu.f > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_sv32_mmu > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see sim.log"
  exit 1
fi

//--- sv32_mmu.f
verilog/sv32_pkg.sv
verilog/page_perm_check.sv
verilog/sv32_tlb.sv
verilog/sv32_page_walker.sv
verilog/sv32_mmu.sv
tests/sv32_mmu_tb.sv

//--- tests/sv32_mmu_tb.sv
`default_nettype none
`timescale 1ns/1ps

module sv32_mmu_tb import sv32_pkg::*; ();

  localparam logic [PPN_W-1:0] ROOT_PPN = 22'h00100;
  localparam int NUM_RANDOM = 400;
  // directed requests plus the random mix
  localparam int NUM_REQS = NUM_RANDOM + 60;
  // two reads of up to 4 cycles each plus fsm and idle cycles, rounded up
  localparam int CYCLES_PER_REQ = 24;
  localparam longint WATCHDOG_NS = longint'(NUM_REQS * CYCLES_PER_REQ + 200) * 40;

  logic               clk;
  logic               arst_n;
  logic               req;
  logic [31:0]        vaddr;
  access_t            access;
  priv_t              priv;
  logic               sum;
  logic               mxr;
  logic               sv32_en;
  logic [PPN_W-1:0]   satp_ppn;
  logic               flush;
  logic               done;
  logic [PADDR_W-1:0] paddr;
  logic               fault_load_page;
  logic               fault_store_page;
  logic               fault_insn_page;
  logic               busy;
  logic               mem_req;
  logic [PADDR_W-1:0] mem_addr;
  logic               mem_valid;
  logic [31:0]        mem_rdata;

  integer             seed;
  int                 errors;
  int                 nreq;
  // sparse page table memory, keyed by byte address
  logic [31:0]        pt_mem [logic [PADDR_W-1:0]];
  int                 mem_lat;
  logic [PADDR_W-1:0] mem_addr_q;
  logic [31:0]        rnd_mem;
  int                 reads_seen;
  // time of the most recent mem_valid pulse
  time                last_valid_t;
  // model of the tlb contents, same round-robin replacement
  logic               mt_valid [TLB_ENTRIES];
  logic [VPN_W-1:0]   mt_vpn1  [TLB_ENTRIES];
  logic [VPN_W-1:0]   mt_vpn0  [TLB_ENTRIES];
  logic               mt_lvl   [TLB_ENTRIES];
  int                 mt_victim;

  sv32_mmu sv32_mmu_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] pt_read(input logic [PADDR_W-1:0] a);
    if (pt_mem.exists(a)) return pt_mem[a];
    return 32'h0;
  endfunction

  function automatic logic [PADDR_W-1:0] pte_addr(input logic [PPN_W-1:0] ppn, input int idx);
    return {ppn, 12'h000} + PADDR_W'(idx * PTE_BYTES);
  endfunction

  // memory answers one read 1 to 4 cycles later
  always @(negedge clk) begin
    if (mem_valid) mem_valid = 1'b0;
    if (mem_lat > 0) begin
      mem_lat = mem_lat - 1;
      if (mem_lat == 0) begin
        mem_valid = 1'b1;
        mem_rdata = pt_read(mem_addr_q);
        last_valid_t = $time;
      end
    end else if (mem_req === 1'b1) begin
      mem_addr_q = mem_addr;
      reads_seen++;
      rnd_mem = $random(seed);
      mem_lat = 1 + int'(rnd_mem[1:0]);
    end
  end

  // leaf with mostly sane bits and now and then a bad one
  function automatic logic [31:0] random_leaf(input logic [PPN_W-1:0] ppn);
    logic [31:0] r;
    logic [9:0]  p;
    r = $random(seed);
    p = r[9:0];
    p[0] = (r[13:10] != 4'h0);
    p[5] = 1'b0;
    p[6] = (r[16:14] != 3'h0);
    p[7] = (r[18:17] != 2'h0);
    p[9:8] = (r[22:19] == 4'h0) ? 2'b10 : 2'b00;
    // keep a few pointers so level-0 pointers show up
    if (!p[1] && !p[3] && (r[24:23] != 2'h0)) p[1] = 1'b1;
    return {ppn, p};
  endfunction

  task automatic build_tables();
    logic [31:0]      rnd;
    logic [31:0]      rnd2;
    logic [PPN_W-1:0] l0_ppn;
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      case (rnd[1:0])
        // superpage, rarely misaligned
        2'd0: pt_mem[pte_addr(ROOT_PPN, i)] =
            random_leaf({rnd[13:2], (rnd[17:14] == 4'h0) ? 10'h001 : 10'h000});
        2'd1, 2'd2: begin
          l0_ppn = 22'h200 + PPN_W'(i);
          // pointer, sometimes with w and no r
          pt_mem[pte_addr(ROOT_PPN, i)] = {l0_ppn, (rnd[7:4] == 4'h0) ? 10'h005 : 10'h001};
          for (int j = 0; j < 16; j++) begin
            rnd2 = $random(seed);
            pt_mem[pte_addr(l0_ppn, j)] = random_leaf(rnd2[21:0]);
          end
        end
        default: ;
      endcase
    end
  endtask

  // leaf rules: returns fault, leaf says r or x set
  function automatic logic pte_fault(input logic [31:0] pte, input logic lvl,
                                     input access_t a, input priv_t p, input logic s,
                                     input logic m, output logic leaf);
    logic v, r, w, x, u, ab, d;
    v  = pte[0];
    r  = pte[1];
    w  = pte[2];
    x  = pte[3];
    u  = pte[4];
    ab = pte[6];
    d  = pte[7];
    leaf = 1'b0;
    if (!v || (w && !r) || (pte[9:8] != 2'b00)) return 1'b1;
    // pointer is only legal at the root
    if (!r && !x) return (lvl == 1'b0);
    leaf = 1'b1;
    if ((a == ACCESS_LOAD) && !(r || (m && x))) return 1'b1;
    if ((a == ACCESS_STORE) && !w) return 1'b1;
    if ((a == ACCESS_INSN) && !x) return 1'b1;
    if ((p == U_MODE) && !u) return 1'b1;
    if ((p == S_MODE) && u && (!s || (a == ACCESS_INSN))) return 1'b1;
    if (lvl && (pte[19:10] != 10'h0)) return 1'b1;
    if (!ab) return 1'b1;
    if ((a == ACCESS_STORE) && !d) return 1'b1;
    return 1'b0;
  endfunction

  task automatic model_walk(input logic [31:0] va, input access_t acc, input priv_t pv,
                            input logic s, input logic m, output logic [PADDR_W-1:0] pa,
                            output logic flt, output int nreads, output logic fill);
    logic [PPN_W-1:0] ppn;
    logic [31:0]      pte;
    logic             leaf;
    logic             stop;
    logic             lvl;
    ppn = ROOT_PPN;
    pa = '0;
    flt = 1'b0;
    fill = 1'b0;
    nreads = 0;
    stop = 1'b0;
    lvl = 1'b1;
    for (int k = 0; k < 2; k++) begin
      if (!stop) begin
        pte = pt_read(pte_addr(ppn, lvl ? int'(va[31:22]) : int'(va[21:12])));
        nreads++;
        flt = pte_fault(pte, lvl, acc, pv, s, m, leaf);
        if (flt) begin
          stop = 1'b1;
        end else if (leaf) begin
          stop = 1'b1;
          fill = 1'b1;
          pa = lvl ? {pte[31:20], va[21:0]} : {pte[31:10], va[11:0]};
        end else begin
          ppn = pte[31:10];
          lvl = 1'b0;
        end
      end
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic do_request(input logic [31:0] va, input access_t acc, input priv_t pv,
                            input logic s, input logic m, input logic en);
    logic [PADDR_W-1:0] exp_pa;
    logic               exp_flt;
    int                 exp_reads;
    logic               exp_fill;
    logic               hit;
    int                 cycles;
    hit = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (en && !hit && mt_valid[i] && (mt_vpn1[i] == va[31:22]) &&
          (mt_lvl[i] || (mt_vpn0[i] == va[21:12]))) hit = 1'b1;
    end
    if (!en) begin
      exp_pa = {2'b00, va};
      exp_flt = 1'b0;
      exp_reads = 0;
      exp_fill = 1'b0;
    end else begin
      model_walk(va, acc, pv, s, m, exp_pa, exp_flt, exp_reads, exp_fill);
      // a hit reuses the cached pte, no reads
      if (hit) exp_reads = 0;
    end
    reads_seen = 0;
    nreq++;
    req = 1'b1;
    vaddr = va;
    access = acc;
    priv = pv;
    sum = s;
    mxr = m;
    sv32_en = en;
    @(negedge clk);
    req = 1'b0;
    cycles = 1;
    // busy is up from the cycle after req
    check_flag("busy", busy, 1'b1);
    while (done !== 1'b1) begin
      @(negedge clk);
      cycles++;
    end
    if ((!en || hit) && (cycles != 1)) begin
      errors++;
      $display("done came %0d cycles after req on a bare or hit request at %0t", cycles, $time);
    end
    // a walk ends with done two edges after the last mem_valid
    if (en && !hit && (($time - last_valid_t) != 64'd80)) begin
      errors++;
      $display("error at %0t: done delay after mem_valid got %0d ns expected 80 ns",
               $time, $time - last_valid_t);
    end
    check_flag("busy", busy, 1'b1);
    if (!exp_flt && (paddr !== exp_pa)) begin
      errors++;
      $display("error at %0t: paddr got %h expected %h", $time, paddr, exp_pa);
    end
    check_flag("fault_load_page", fault_load_page, exp_flt && (acc == ACCESS_LOAD));
    check_flag("fault_store_page", fault_store_page, exp_flt && (acc == ACCESS_STORE));
    check_flag("fault_insn_page", fault_insn_page, exp_flt && (acc == ACCESS_INSN));
    if (reads_seen != exp_reads) begin
      errors++;
      $display("error at %0t: mem_req count got %0d expected %0d", $time, reads_seen, exp_reads);
    end
    // faulted walks are not cached
    if (en && !hit && exp_fill) begin
      mt_valid[mt_victim] = 1'b1;
      mt_vpn1[mt_victim] = va[31:22];
      mt_vpn0[mt_victim] = va[21:12];
      mt_lvl[mt_victim] = (pt_read(pte_addr(ROOT_PPN, int'(va[31:22]))) & 32'h0000_000a) != 0;
      mt_victim = (mt_victim + 1) % TLB_ENTRIES;
    end
    // busy drops one edge after done
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
  endtask

  task automatic do_flush();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) mt_valid[i] = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("run did not finish in time, a request or the memory port hung");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] va;
    seed = 32'hb7b7_36ab;
    errors = 0;
    nreq = 0;
    arst_n = 1'b0;
    req = 1'b0;
    vaddr = '0;
    access = ACCESS_LOAD;
    priv = S_MODE;
    sum = 1'b0;
    mxr = 1'b0;
    sv32_en = 1'b0;
    satp_ppn = ROOT_PPN;
    flush = 1'b0;
    mem_valid = 1'b0;
    mem_rdata = '0;
    mem_lat = 0;
    reads_seen = 0;
    last_valid_t = 0;
    mt_victim = 0;
    for (int i = 0; i < TLB_ENTRIES; i++) mt_valid[i] = 1'b0;
    build_tables();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // bare mode
    do_request(32'h8000_1234, ACCESS_LOAD, S_MODE, 1'b0, 1'b0, 1'b0);
    do_request(32'hffff_fffc, ACCESS_STORE, U_MODE, 1'b0, 1'b0, 1'b0);
    do_request(32'h0000_0000, ACCESS_INSN, M_MODE, 1'b0, 1'b0, 1'b0);

    // cold walks, then hits with the same and another access kind
    for (int i = 0; i < 16; i++) begin
      va = {VPN_W'(i), VPN_W'(i), 12'h5a4};
      do_request(va, ACCESS_LOAD, S_MODE, 1'b1, 1'b0, 1'b1);
      do_request(va, ACCESS_LOAD, S_MODE, 1'b1, 1'b0, 1'b1);
      do_request(va, ACCESS_STORE, U_MODE, 1'b0, 1'b1, 1'b1);
    end

    // previously hit pages walk again after a flush
    do_flush();
    for (int i = 8; i < 16; i++) begin
      do_request({VPN_W'(i), VPN_W'(i), 12'h010}, ACCESS_LOAD, S_MODE, 1'b1, 1'b0, 1'b1);
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = $random(seed);
      if (r[9:5] == 5'h0) do_flush();
      va = $random(seed);
      // keep most addresses inside the built tables
      if (r[4]) va = {6'h0, va[25:22], 6'h0,
                      ((va[15:0] % 16'd20) == 16'd0) ? 4'hf : va[15:12], va[11:0]};
      do_request(va,
                 (r[3:2] == 2'd0) ? ACCESS_LOAD : (r[3:2] == 2'd1) ? ACCESS_STORE : ACCESS_INSN,
                 (r[1:0] == 2'd0) ? U_MODE : (r[1:0] == 2'd1) ? S_MODE : M_MODE,
                 r[10], r[11], r[14:12] != 3'h0);
    end

    $display("requests: %0d, errors: %0d", nreq, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/page_perm_check.sv
`default_nettype none
`timescale 1ns/1ps

module page_perm_check import sv32_pkg::*; (
  input  logic       check,
  input  pte_level_t level,
  input  access_t    access,
  input  pte_sv32_t  pte_sv32,
  input  priv_t      priv,
  input  logic       sum,
  input  logic       mxr,
  output logic       fault_load_page,
  output logic       fault_store_page,
  output logic       fault_insn_page,
  output logic       leaf_pte
);

  pte_perms_t perms;
  // one page fault of whatever kind the access is
  logic       page_fault;
  // user page touched from the wrong side
  logic       us_violation;

  assign perms = pte_sv32.perms;

  // s-mode may read/write user pages only with sum, and never fetch from them
  // u-mode may only touch user pages
  assign us_violation =
      (perms.user & (priv == S_MODE) & (~sum | (access == ACCESS_INSN))) |
      (~perms.user & (priv == U_MODE));

  always_comb begin
    page_fault = 1'b0;
    leaf_pte   = 1'b0;

    if (check) begin
      // malformed pte: not valid, w without r, or reserved bits in use
      if (~perms.valid | (~perms.readable & perms.writable) | (|perms.reserved_0)) begin
        page_fault = 1'b1;
      end
      // r or x set means a leaf
      else if (perms.readable | perms.executable) begin
        leaf_pte = 1'b1;

        // loads need r, or x when mxr is set
        if ((access == ACCESS_LOAD) & ~perms.readable & ~(mxr & perms.executable)) begin
          page_fault = 1'b1;
        end
        // fetch needs x
        else if ((access == ACCESS_INSN) & ~perms.executable) begin
          page_fault = 1'b1;
        end
        // store needs w
        else if ((access == ACCESS_STORE) & ~perms.writable) begin
          page_fault = 1'b1;
        end
        else if (us_violation) begin
          page_fault = 1'b1;
        end
        // 4 MiB superpage must have ppn[0] clear
        else if ((level == LEVEL_ROOT) & (|pte_sv32.ppn[VPN_W-1:0])) begin
          page_fault = 1'b1;
        end
        // svade, no hardware a/d update so a clear bit faults
        else if (~perms.accessed) begin
          page_fault = 1'b1;
        end
        else if ((access == ACCESS_STORE) & ~perms.dirty) begin
          page_fault = 1'b1;
        end
      end
      // pointer in the last level table has nowhere to go
      else if (level == LEVEL_LEAF) begin
        page_fault = 1'b1;
      end
      // otherwise a pointer at level 1, the walker descends
    end
  end

  // fault is reported on the flag of the access kind only
  assign fault_load_page  = page_fault & (access == ACCESS_LOAD);
  assign fault_store_page = page_fault & (access == ACCESS_STORE);
  assign fault_insn_page  = page_fault & (access == ACCESS_INSN);

  // every fault shows up on exactly one flag
  always_comb begin
    assert (!page_fault || $onehot({fault_load_page, fault_store_page, fault_insn_page}))
      else $error("page_perm_check: page fault not reported on exactly one flag");
  end

endmodule

`default_nettype wire

//--- verilog/sv32_mmu.sv
`default_nettype none
`timescale 1ns/1ps

module sv32_mmu import sv32_pkg::*; (
  input  logic               clk,
  input  logic               arst_n,
  // request side
  input  logic               req,
  input  logic [31:0]        vaddr,
  input  access_t            access,
  input  priv_t              priv,
  input  logic               sum,
  input  logic               mxr,
  input  logic               sv32_en,
  input  logic [PPN_W-1:0]   satp_ppn,
  input  logic               flush,
  // response side
  output logic               done,
  output logic [PADDR_W-1:0] paddr,
  output logic               fault_load_page,
  output logic               fault_store_page,
  output logic               fault_insn_page,
  output logic               busy,
  // pte read port
  output logic               mem_req,
  output logic [PADDR_W-1:0] mem_addr,
  input  logic               mem_valid,
  input  logic [31:0]        mem_rdata
);

  // tlb to walker
  logic               walk_start;
  // walker to tlb
  logic               walk_done;
  logic [PADDR_W-1:0] walk_paddr;
  logic               walk_fault_load;
  logic               walk_fault_store;
  logic               walk_fault_insn;
  logic               walk_fill;
  pte_sv32_t          walk_pte;
  pte_level_t         walk_level;

  sv32_tlb tlb_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .req              (req),
    .flush            (flush),
    .vaddr            (vaddr),
    .access           (access),
    .priv             (priv),
    .sum              (sum),
    .mxr              (mxr),
    .sv32_en          (sv32_en),
    .walk_done        (walk_done),
    .walk_paddr       (walk_paddr),
    .walk_fault_load  (walk_fault_load),
    .walk_fault_store (walk_fault_store),
    .walk_fault_insn  (walk_fault_insn),
    .walk_fill        (walk_fill),
    .walk_pte         (walk_pte),
    .walk_level       (walk_level),
    .done             (done),
    .busy             (busy),
    .paddr            (paddr),
    .fault_load_page  (fault_load_page),
    .fault_store_page (fault_store_page),
    .fault_insn_page  (fault_insn_page),
    .walk_start       (walk_start)
  );

  // request fields are held by the requester during the walk
  sv32_page_walker walker_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .walk_start       (walk_start),
    .vaddr            (vaddr),
    .access           (access),
    .priv             (priv),
    .sum              (sum),
    .mxr              (mxr),
    .satp_ppn         (satp_ppn),
    .mem_valid        (mem_valid),
    .mem_rdata        (mem_rdata),
    .mem_req          (mem_req),
    .mem_addr         (mem_addr),
    .walk_done        (walk_done),
    .walk_paddr       (walk_paddr),
    .walk_fault_load  (walk_fault_load),
    .walk_fault_store (walk_fault_store),
    .walk_fault_insn  (walk_fault_insn),
    .walk_fill        (walk_fill),
    .walk_pte         (walk_pte),
    .walk_level       (walk_level)
  );

endmodule

`default_nettype wire

//--- verilog/sv32_page_walker.sv
`default_nettype none
`timescale 1ns/1ps

module sv32_page_walker import sv32_pkg::*; (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               walk_start,
  input  logic [31:0]        vaddr,
  input  access_t            access,
  input  priv_t              priv,
  input  logic               sum,
  input  logic               mxr,
  input  logic [PPN_W-1:0]   satp_ppn,
  input  logic               mem_valid,
  input  logic [31:0]        mem_rdata,
  output logic               mem_req,
  output logic [PADDR_W-1:0] mem_addr,
  output logic               walk_done,
  output logic [PADDR_W-1:0] walk_paddr,
  output logic               walk_fault_load,
  output logic               walk_fault_store,
  output logic               walk_fault_insn,
  output logic               walk_fill,
  output pte_sv32_t          walk_pte,
  output pte_level_t         walk_level
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ_L1,
    S_WAIT_L1,
    S_READ_L0,
    S_WAIT_L0,
    S_DONE
  } walk_state_t;

  walk_state_t        state_q;
  walk_state_t        state_d;

  // base ppn of the table being read
  logic [PPN_W-1:0]   table_ppn_q;
  pte_level_t         cur_level;
  logic [VPN_W-1:0]   cur_vpn;

  pte_sv32_t          rd_pte;
  logic               pte_arrived;
  logic               walk_end;
  logic [PADDR_W-1:0] leaf_paddr;

  logic               chk_fault_load;
  logic               chk_fault_store;
  logic               chk_fault_insn;
  logic               chk_leaf;

  // result held for the done cycle
  logic               fault_load_q;
  logic               fault_store_q;
  logic               fault_insn_q;
  logic               fill_q;

  assign rd_pte = pte_sv32_t'(mem_rdata);

  assign cur_level = ((state_q == S_READ_L1) || (state_q == S_WAIT_L1)) ?
                     LEVEL_ROOT : LEVEL_LEAF;
  assign cur_vpn   = (cur_level == LEVEL_ROOT) ? vaddr[31 -: VPN_W] :
                                                 vaddr[PAGE_OFFSET_W +: VPN_W];

  // pte address = table base + vpn field * pte size
  assign mem_req  = (state_q == S_READ_L1) || (state_q == S_READ_L0);
  assign mem_addr = (PADDR_W'(table_ppn_q) << PAGE_OFFSET_W) +
                    PADDR_W'(cur_vpn) * PADDR_W'(PTE_BYTES);

  assign pte_arrived = mem_valid && ((state_q == S_WAIT_L1) || (state_q == S_WAIT_L0));

  page_perm_check walk_check_i (
    .check            (pte_arrived),
    .level            (cur_level),
    .access           (access),
    .pte_sv32         (rd_pte),
    .priv             (priv),
    .sum              (sum),
    .mxr              (mxr),
    .fault_load_page  (chk_fault_load),
    .fault_store_page (chk_fault_store),
    .fault_insn_page  (chk_fault_insn),
    .leaf_pte         (chk_leaf)
  );

  // any fault or a leaf finishes, only a clean level-1 pointer descends
  assign walk_end = chk_leaf | chk_fault_load | chk_fault_store | chk_fault_insn;

  // superpage: ppn[1] with vpn[0] and offset
  assign leaf_paddr = (cur_level == LEVEL_ROOT) ?
      {rd_pte.ppn[PPN_W-1:VPN_W], vaddr[VPN_W+PAGE_OFFSET_W-1:0]} :
      {rd_pte.ppn, vaddr[PAGE_OFFSET_W-1:0]};

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:    if (walk_start) state_d = S_READ_L1;
      S_READ_L1: state_d = S_WAIT_L1;
      S_WAIT_L1: begin
        if (mem_valid) begin
          state_d = walk_end ? S_DONE : S_READ_L0;
        end
      end
      S_READ_L0: state_d = S_WAIT_L0;
      // a pointer at level 0 faults in the checker, so always done
      S_WAIT_L0: if (mem_valid) state_d = S_DONE;
      S_DONE:    state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // table base and captured pte
  always_ff @(posedge clk) begin
    if (walk_start && (state_q == S_IDLE)) begin
      table_ppn_q <= satp_ppn;
    end else if (pte_arrived && !walk_end) begin
      table_ppn_q <= rd_pte.ppn;
    end
    if (pte_arrived) begin
      walk_pte      <= rd_pte;
      walk_level    <= cur_level;
      walk_paddr    <= leaf_paddr;
      fault_load_q  <= chk_fault_load;
      fault_store_q <= chk_fault_store;
      fault_insn_q  <= chk_fault_insn;
      fill_q        <= chk_leaf & ~(chk_fault_load | chk_fault_store | chk_fault_insn);
    end
  end

  // results only count in the done cycle
  assign walk_done        = (state_q == S_DONE);
  assign walk_fault_load  = walk_done & fault_load_q;
  assign walk_fault_store = walk_done & fault_store_q;
  assign walk_fault_insn  = walk_done & fault_insn_q;
  assign walk_fill        = walk_done & fill_q;

  // memory must only answer a read that this walker issued
  assert property (@(posedge clk) disable iff (!arst_n)
      mem_valid |-> ((state_q == S_WAIT_L1) || (state_q == S_WAIT_L0)))
    else $error("sv32_page_walker: mem_valid without outstanding read");

endmodule

`default_nettype wire

//--- verilog/sv32_pkg.sv
`default_nettype none

package sv32_pkg;

  // sv32 virtual address split: vpn[1] | vpn[0] | page offset
  localparam int PAGE_OFFSET_W = 12;
  // width of one vpn field, also the index into one page table
  localparam int VPN_W = 10;
  // ppn width in a pte and in satp
  localparam int PPN_W = 22;
  // physical address is ppn concatenated with the page offset
  localparam int PADDR_W = PPN_W + PAGE_OFFSET_W;
  // one pte is a 32-bit word
  localparam int PTE_BYTES = 4;

  // fully associative tlb, power of two from 2 to 32
  localparam int TLB_ENTRIES = 8;
  localparam int TLB_IDX_W = $clog2(TLB_ENTRIES);

  // kind of access being translated
  typedef enum logic [1:0] {
    ACCESS_LOAD  = 2'b00,
    ACCESS_STORE = 2'b01,
    ACCESS_INSN  = 2'b10
  } access_t;

  // privilege encoding as in the mstatus mpp field
  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    S_MODE = 2'b01,
    M_MODE = 2'b11
  } priv_t;

  // low ten bits of a pte, msb first
  typedef struct packed {
    logic [1:0] reserved_0;
    logic       dirty;
    logic       accessed;
    logic       global;
    logic       user;
    logic       executable;
    logic       writable;
    logic       readable;
    logic       valid;
  } pte_perms_t;

  // full sv32 pte
  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    pte_perms_t       perms;
  } pte_sv32_t;

  // walk level, root table is level 1
  typedef logic pte_level_t;

  localparam pte_level_t LEVEL_ROOT = 1'b1;
  localparam pte_level_t LEVEL_LEAF = 1'b0;

endpackage

`default_nettype wire

//--- verilog/sv32_tlb.sv
`default_nettype none
`timescale 1ns/1ps

module sv32_tlb import sv32_pkg::*; (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               req,
  input  logic               flush,
  input  logic [31:0]        vaddr,
  input  access_t            access,
  input  priv_t              priv,
  input  logic               sum,
  input  logic               mxr,
  input  logic               sv32_en,
  input  logic               walk_done,
  input  logic [PADDR_W-1:0] walk_paddr,
  input  logic               walk_fault_load,
  input  logic               walk_fault_store,
  input  logic               walk_fault_insn,
  input  logic               walk_fill,
  input  pte_sv32_t          walk_pte,
  input  pte_level_t         walk_level,
  output logic               done,
  output logic               busy,
  output logic [PADDR_W-1:0] paddr,
  output logic               fault_load_page,
  output logic               fault_store_page,
  output logic               fault_insn_page,
  output logic               walk_start
);

  // entry storage, only valid bits are reset
  logic [TLB_ENTRIES-1:0] valid_q;
  logic [VPN_W-1:0]       tag_vpn1_q [TLB_ENTRIES];
  logic [VPN_W-1:0]       tag_vpn0_q [TLB_ENTRIES];
  pte_sv32_t              pte_q      [TLB_ENTRIES];
  pte_level_t             level_q    [TLB_ENTRIES];
  // round-robin victim pointer, wraps by itself
  logic [TLB_IDX_W-1:0]   victim_q;

  logic [VPN_W-1:0]       vpn1;
  logic [VPN_W-1:0]       vpn0;
  logic                   hit;
  logic [TLB_IDX_W-1:0]   hit_idx;
  pte_sv32_t              hit_pte;
  pte_level_t             hit_level;
  logic [PADDR_W-1:0]     hit_paddr;
  logic                   hit_check;
  logic                   chk_fault_load;
  logic                   chk_fault_store;
  logic                   chk_fault_insn;

  assign vpn1 = vaddr[31 -: VPN_W];
  assign vpn0 = vaddr[PAGE_OFFSET_W +: VPN_W];

  // superpage entries ignore vpn[0]
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (!hit && valid_q[i] && (tag_vpn1_q[i] == vpn1) &&
          ((level_q[i] == LEVEL_ROOT) || (tag_vpn0_q[i] == vpn0))) begin
        hit     = 1'b1;
        hit_idx = TLB_IDX_W'(i);
      end
    end
  end

  assign hit_pte   = pte_q[hit_idx];
  assign hit_level = level_q[hit_idx];

  // superpage keeps vpn[0] and offset from the virtual address
  assign hit_paddr = (hit_level == LEVEL_ROOT) ?
      {hit_pte.ppn[PPN_W-1:VPN_W], vaddr[VPN_W+PAGE_OFFSET_W-1:0]} :
      {hit_pte.ppn, vaddr[PAGE_OFFSET_W-1:0]};

  // cached entries are faultless leaves, but access kind and privilege may differ
  assign hit_check = req & sv32_en & hit;

  page_perm_check hit_check_i (
    .check            (hit_check),
    .level            (hit_level),
    .access           (access),
    .pte_sv32         (hit_pte),
    .priv             (priv),
    .sum              (sum),
    .mxr              (mxr),
    .fault_load_page  (chk_fault_load),
    .fault_store_page (chk_fault_store),
    .fault_insn_page  (chk_fault_insn),
    .leaf_pte         ()
  );

  // miss goes to the walker in the request cycle
  assign walk_start = req & sv32_en & ~hit;

  // response control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done             <= 1'b0;
      busy             <= 1'b0;
      fault_load_page  <= 1'b0;
      fault_store_page <= 1'b0;
      fault_insn_page  <= 1'b0;
    end else begin
      done <= 1'b0;
      // busy covers the cycles after req up to and including done
      if (req) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
      if (req && !sv32_en) begin
        done             <= 1'b1;
        fault_load_page  <= 1'b0;
        fault_store_page <= 1'b0;
        fault_insn_page  <= 1'b0;
      end else if (req && hit) begin
        done             <= 1'b1;
        fault_load_page  <= chk_fault_load;
        fault_store_page <= chk_fault_store;
        fault_insn_page  <= chk_fault_insn;
      end else if (walk_done) begin
        done             <= 1'b1;
        fault_load_page  <= walk_fault_load;
        fault_store_page <= walk_fault_store;
        fault_insn_page  <= walk_fault_insn;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req && !sv32_en) begin
      paddr <= {{(PADDR_W-32){1'b0}}, vaddr};
    end else if (req && hit) begin
      paddr <= hit_paddr;
    end else if (walk_done) begin
      paddr <= walk_paddr;
    end
  end

  // valid bits and victim pointer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush) begin
      valid_q <= '0;
    end else if (walk_fill) begin
      valid_q[victim_q] <= 1'b1;
      victim_q          <= victim_q + 1'b1;
    end
  end

  // tag and pte of a new entry, vaddr is still held by the requester
  always_ff @(posedge clk) begin
    if (walk_fill) begin
      tag_vpn1_q[victim_q] <= vpn1;
      tag_vpn0_q[victim_q] <= vpn0;
      pte_q[victim_q]      <= walk_pte;
      level_q[victim_q]    <= walk_level;
    end
  end

  // requester must wait for done before the next request
  assert property (@(posedge clk) disable iff (!arst_n) req |-> !busy)
    else $error("sv32_tlb: req while busy");

  // walker answers only a walk that is in progress
  assert property (@(posedge clk) disable iff (!arst_n) walk_done |-> busy)
    else $error("sv32_tlb: walk_done while idle");

endmodule

`default_nettype wire
